//--- flist.f
+incdir+verilog
verilog/game_pkg.sv
verilog/game_cen.sv
verilog/rom_slot.sv
verilog/bank_arbiter.sv
verilog/prog_loader.sv
verilog/game_top.sv
sim/game_sva.sv
sim/game_tb.sv

//--- Bender.yml
package:
  name: game_mem

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/game_pkg.sv
      - verilog/game_cen.sv
      - verilog/rom_slot.sv
      - verilog/bank_arbiter.sv
      - verilog/prog_loader.sv
      - verilog/game_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/game_sva.sv
      - sim/game_tb.sv

//--- sim/game_tb.sv
// Testbench for the game memory slice with ROM reads, a ROM download and an SDRAM bank model
`timescale 1ns/1ps
`default_nettype none

`include "game_consts.svh"

module game_tb;

    localparam int          HALF_PERIOD  = 20;
    localparam logic [15:0] BANK_XOR     = 16'hA5C3;
    // Worst miss is 3 ack plus 4 rdy cycles plus slot and arbiter turnaround
    localparam int          MISS_CYCLES  = 12;
    localparam int          N_MISS       = 8;
    // Reset, hits, turbo window and the download
    localparam int          FIXED_CYCLES = 104;
    localparam int          WATCHDOG_CYCLES = 2 * (N_MISS * MISS_CYCLES + FIXED_CYCLES);

    logic                    VB;
    logic                    arst_n;
    logic                    turbo;
    logic                    pxl_cen;
    logic                    cpu_cen;
    logic                    main_cs;
    logic [`GAME_ROM_AW-1:0] main_addr;
    logic [`GAME_DW-1:0]     main_data;
    logic                    main_ok;
    logic                    gfx_cs;
    logic [`GAME_ROM_AW-1:0] gfx_addr;
    logic [`GAME_DW-1:0]     gfx_data;
    logic                    gfx_ok;
    logic [`GAME_BA_AW-1:0]  ba_addr;
    logic                    ba_rd;
    logic                    ba_ack;
    logic                    ba_rdy;
    logic [`GAME_DW-1:0]     data_read;
    logic                    downloading;
    logic                    dwnld_busy;
    logic [24:0]             ioctl_addr;
    logic [7:0]              ioctl_data;
    logic                    ioctl_wr;
    logic [`GAME_BA_AW-1:0]  prog_addr;
    logic [`GAME_DW-1:0]     prog_data;
    logic                    prog_we;
    integer                  seed;

    game_top dut (.*);

    bind game_top game_sva u_sva (.*);

    initial begin
        VB = 1'b0;
        forever begin
            #HALF_PERIOD VB = ~VB;
        end
    end

    // SDRAM bank, ack after 1 to 3 cycles and rdy 1 to 4 cycles later
    initial begin : bank_model
        int                     wait_cycles;
        logic [`GAME_BA_AW-1:0] rd_addr;
        forever begin
            @(negedge VB);
            if (ba_rd) begin
                rd_addr     = ba_addr;
                wait_cycles = $unsigned($random(seed)) % 3;
                repeat (wait_cycles) @(negedge VB);
                ba_ack = 1'b1;
                @(negedge VB);
                ba_ack      = 1'b0;
                wait_cycles = $unsigned($random(seed)) % 4;
                repeat (wait_cycles) @(negedge VB);
                ba_rdy    = 1'b1;
                data_read = rd_addr[15:0] ^ BANK_XOR;
                @(negedge VB);
                ba_rdy = 1'b0;
            end
        end
    end

    // Hold cs with a stable address until every selected client reports ok
    task automatic rom_read(input logic use_main, input logic [`GAME_ROM_AW-1:0] m_addr,
                            input logic use_gfx, input logic [`GAME_ROM_AW-1:0] g_addr);
        @(negedge VB);
        main_cs   = use_main;
        main_addr = m_addr;
        gfx_cs    = use_gfx;
        gfx_addr  = g_addr;
        do begin
            @(negedge VB);
        end while (!((main_ok || !use_main) && (gfx_ok || !use_gfx)));
        main_cs = 1'b0;
        gfx_cs  = 1'b0;
    endtask

    // Low byte of each word goes first
    task automatic load_bytes(input logic [24:0] start, input int count);
        for (int i = 0; i < count; i++) begin
            @(negedge VB);
            ioctl_addr = start + 25'(i);
            ioctl_data = 8'(i * 37 + 8'h3C);
            ioctl_wr   = 1'b1;
            @(negedge VB);
            ioctl_wr = 1'b0;
        end
    endtask

    initial begin : stimulus
        int unsigned errors;
        seed        = 32'h0c595811;
        arst_n      = 1'b0;
        turbo       = 1'b0;
        main_cs     = 1'b0;
        main_addr   = '0;
        gfx_cs      = 1'b0;
        gfx_addr    = '0;
        ba_ack      = 1'b0;
        ba_rdy      = 1'b0;
        data_read   = '0;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        ioctl_wr    = 1'b0;
        repeat (2) @(posedge VB);
        @(negedge VB);
        arst_n = 1'b1;

        // Miss then hit on each client
        rom_read(1'b1, 20'h00012, 1'b0, '0);
        rom_read(1'b1, 20'h00012, 1'b0, '0);
        rom_read(1'b0, '0, 1'b1, 20'h00345);
        rom_read(1'b0, '0, 1'b1, 20'h00345);
        // Both slots miss in the same cycle
        rom_read(1'b1, 20'h0ABCD, 1'b1, 20'hF1111);
        rom_read(1'b1, 20'h0ABCD, 1'b1, 20'hF1111);
        rom_read(1'b1, 20'h5A5A5, 1'b1, 20'h00346);

        @(negedge VB);
        turbo = 1'b1;
        repeat (12) @(negedge VB);
        turbo = 1'b0;
        repeat (8) @(negedge VB);

        // ROM download while a main read waits for the bank
        @(negedge VB);
        downloading = 1'b1;
        main_cs     = 1'b1;
        main_addr   = 20'h00777;
        load_bytes(25'h0000040, 6);
        @(negedge VB);
        downloading = 1'b0;
        do begin
            @(negedge VB);
        end while (!main_ok);
        main_cs = 1'b0;
        repeat (4) @(negedge VB);

        errors = dut.u_sva.err_cnt;
        $display("Run complete: %0d assertion errors, 0 timeouts", errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge VB);
        $display("Watchdog expired after %0d cycles before the run completed", WATCHDOG_CYCLES);
        $display("Run stopped: %0d assertion errors, 1 timeout", dut.u_sva.err_cnt);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/game_sva.sv
// Concurrent checks on the game memory slice, bound into game_top by the testbench
`timescale 1ns/1ps
`default_nettype none

`include "game_consts.svh"

module game_sva (
    input logic                    VB,
    input logic                    arst_n,
    input logic                    turbo,
    input logic                    pxl_cen,
    input logic                    cpu_cen,
    input logic                    main_cs,
    input logic [`GAME_ROM_AW-1:0] main_addr,
    input logic [`GAME_DW-1:0]     main_data,
    input logic                    main_ok,
    input logic                    main_req,
    input logic [`GAME_ROM_AW-1:0] main_req_addr,
    input logic                    main_resp_valid,
    input logic                    gfx_cs,
    input logic [`GAME_ROM_AW-1:0] gfx_addr,
    input logic [`GAME_DW-1:0]     gfx_data,
    input logic                    gfx_ok,
    input logic                    gfx_req,
    input logic [`GAME_ROM_AW-1:0] gfx_req_addr,
    input logic                    gfx_resp_valid,
    input logic [`GAME_BA_AW-1:0]  ba_addr,
    input logic                    ba_rd,
    input logic                    downloading,
    input logic                    dwnld_busy,
    input logic [24:0]             ioctl_addr,
    input logic [7:0]              ioctl_data,
    input logic                    ioctl_wr,
    input logic [`GAME_BA_AW-1:0]  prog_addr,
    input logic [`GAME_DW-1:0]     prog_data,
    input logic                    prog_we
);

    // Pattern the bank model folds into every read word
    localparam logic [15:0] BANK_XOR = 16'hA5C3;

    int unsigned             err_cnt = 0;
    logic [`GAME_DW-1:0]     main_exp;
    logic [`GAME_DW-1:0]     gfx_exp;
    logic                    main_have;
    logic [`GAME_ROM_AW-1:0] main_last;
    logic                    gfx_have;
    logic [`GAME_ROM_AW-1:0] gfx_last;
    logic [`GAME_BA_AW-1:0]  exp_ba_addr;
    logic [7:0]              even_q;
    logic                    exp_we;
    logic [`GAME_BA_AW-1:0]  exp_prog_addr;
    logic [`GAME_DW-1:0]     exp_prog_data;

    assign main_exp = `GAME_DW'(main_addr) ^ BANK_XOR;
    assign gfx_exp  = `GAME_DW'(`GAME_BA_AW'(gfx_addr) + `GAME_GFX_OFFSET) ^ BANK_XOR;

    // Last word fetched per client is forgotten during a download
    always_ff @(posedge VB or negedge arst_n) begin
        if (!arst_n) begin
            main_have <= 1'b0;
            gfx_have  <= 1'b0;
            exp_we    <= 1'b0;
        end else begin
            if (downloading) begin
                main_have <= 1'b0;
            end else if (main_resp_valid) begin
                main_have <= 1'b1;
            end
            if (downloading) begin
                gfx_have <= 1'b0;
            end else if (gfx_resp_valid) begin
                gfx_have <= 1'b1;
            end
            exp_we <= ioctl_wr & ioctl_addr[0];
        end
    end

    always_ff @(posedge VB) begin
        if (main_resp_valid) begin
            main_last <= main_req_addr;
        end
        if (gfx_resp_valid) begin
            gfx_last <= gfx_req_addr;
        end
        // MAIN wins when both slots ask
        exp_ba_addr <= main_req ? `GAME_BA_AW'(main_req_addr)
                                : `GAME_BA_AW'(gfx_req_addr) + `GAME_GFX_OFFSET;
        if (ioctl_wr && !ioctl_addr[0]) begin
            even_q <= ioctl_data;
        end
        if (ioctl_wr && ioctl_addr[0]) begin
            exp_prog_addr <= `GAME_BA_AW'(ioctl_addr >> 1);
            exp_prog_data <= {ioctl_data, even_q};
        end
    end

    assert property (@(posedge VB) disable iff (!arst_n) main_ok |-> main_data == main_exp)
        else begin
            err_cnt++;
            $error("[FAIL] %0t main_data got %h exp %h", $time, main_data, main_exp);
        end

    assert property (@(posedge VB) disable iff (!arst_n) gfx_ok |-> gfx_data == gfx_exp)
        else begin
            err_cnt++;
            $error("[FAIL] %0t gfx_data got %h exp %h", $time, gfx_data, gfx_exp);
        end

    assert property (@(posedge VB) disable iff (!arst_n) $rose(ba_rd) |-> ba_addr == exp_ba_addr)
        else begin
            err_cnt++;
            $error("[FAIL] %0t ba_addr got %h exp %h", $time, ba_addr, exp_ba_addr);
        end

    assert property (@(posedge VB) disable iff (!arst_n)
        main_cs && main_have && main_addr == main_last |-> main_ok ##1 !main_req)
        else begin
            err_cnt++;
            $error("Cached main read at %0t missed or went back to the bank", $time);
        end

    assert property (@(posedge VB) disable iff (!arst_n)
        gfx_cs && gfx_have && gfx_addr == gfx_last |-> gfx_ok ##1 !gfx_req)
        else begin
            err_cnt++;
            $error("Cached gfx read at %0t missed or went back to the bank", $time);
        end

    assert property (@(posedge VB) disable iff (!arst_n)
        prog_we == exp_we && (!exp_we || {prog_addr, prog_data} == {exp_prog_addr, exp_prog_data}))
        else begin
            err_cnt++;
            $error("[FAIL] %0t prog_we/prog_addr/prog_data got %b/%h/%h exp %b/%h/%h", $time,
                   prog_we, prog_addr, prog_data, exp_we, exp_prog_addr, exp_prog_data);
        end

    assert property (@(posedge VB) disable iff (!arst_n) pxl_cen |=> !pxl_cen [*3] ##1 pxl_cen)
        else begin
            err_cnt++;
            $error("pxl_cen did not repeat every 4 cycles at %0t", $time);
        end

    assert property (@(posedge VB) disable iff (!arst_n) !pxl_cen [*3] |=> pxl_cen)
        else begin
            err_cnt++;
            $error("pxl_cen stayed low for 4 cycles at %0t", $time);
        end

    // At normal speed the CPU runs with the pixel enable
    assert property (@(posedge VB) disable iff (!arst_n) !turbo |=> cpu_cen == pxl_cen)
        else begin
            err_cnt++;
            $error("[FAIL] %0t cpu_cen got %b exp %b", $time, cpu_cen, pxl_cen);
        end

    assert property (@(posedge VB) disable iff (!arst_n)
        cpu_cen |=> !cpu_cen ##1 (cpu_cen || !$past(turbo)))
        else begin
            err_cnt++;
            $error("cpu_cen did not follow the turbo 1 in 2 rate at %0t", $time);
        end

    assert property (@(posedge VB) disable iff (!arst_n)
        downloading |-> dwnld_busy ##1 (!ba_rd || $past(ba_rd)))
        else begin
            err_cnt++;
            $error("Download at %0t was not busy or a bank read started", $time);
        end

endmodule

`default_nettype wire

//--- verilog/game_top.sv
// Game memory-side top level joining enables, ROM slots, bank arbiter and ROM loader
`timescale 1ns/1ps
`default_nettype none

`include "game_consts.svh"

module game_top (
    input  logic                    VB,
    input  logic                    arst_n,
    input  logic                    turbo,
    output logic                    pxl_cen,
    output logic                    cpu_cen,
    // Main CPU ROM client
    input  logic                    main_cs,
    input  logic [`GAME_ROM_AW-1:0] main_addr,
    output logic [`GAME_DW-1:0]     main_data,
    output logic                    main_ok,
    // Graphics ROM client
    input  logic                    gfx_cs,
    input  logic [`GAME_ROM_AW-1:0] gfx_addr,
    output logic [`GAME_DW-1:0]     gfx_data,
    output logic                    gfx_ok,
    // Read-only SDRAM bank
    output logic [`GAME_BA_AW-1:0]  ba_addr,
    output logic                    ba_rd,
    input  logic                    ba_ack,
    input  logic                    ba_rdy,
    input  logic [`GAME_DW-1:0]     data_read,
    // ROM download
    input  logic                    downloading,
    output logic                    dwnld_busy,
    input  logic [24:0]             ioctl_addr,
    input  logic [7:0]              ioctl_data,
    input  logic                    ioctl_wr,
    output logic [`GAME_BA_AW-1:0]  prog_addr,
    output logic [`GAME_DW-1:0]     prog_data,
    output logic                    prog_we
);

    import game_pkg::*;

    logic                    main_req;
    logic [`GAME_ROM_AW-1:0] main_req_addr;
    logic                    main_resp_valid;
    logic                    gfx_req;
    logic [`GAME_ROM_AW-1:0] gfx_req_addr;
    logic                    gfx_resp_valid;
    rom_word_t               arb_resp_data;

    game_cen u_cen (
        .VB         (VB),
        .arst_n     (arst_n),
        .turbo      (turbo),
        .pxl_cen    (pxl_cen),
        .cpu_cen    (cpu_cen)
    );

    // Both caches drop their word while a new ROM is loaded
    rom_slot u_main_slot (
        .VB         (VB),
        .arst_n     (arst_n),
        .flush      (downloading),
        .cs         (main_cs),
        .addr       (main_addr),
        .data       (main_data),
        .ok         (main_ok),
        .req        (main_req),
        .req_addr   (main_req_addr),
        .resp_valid (main_resp_valid),
        .resp_data  (arb_resp_data)
    );

    rom_slot u_gfx_slot (
        .VB         (VB),
        .arst_n     (arst_n),
        .flush      (downloading),
        .cs         (gfx_cs),
        .addr       (gfx_addr),
        .data       (gfx_data),
        .ok         (gfx_ok),
        .req        (gfx_req),
        .req_addr   (gfx_req_addr),
        .resp_valid (gfx_resp_valid),
        .resp_data  (arb_resp_data)
    );

    bank_arbiter u_arbiter (
        .VB              (VB),
        .arst_n          (arst_n),
        .hold            (downloading),
        .main_req        (main_req),
        .main_addr       (main_req_addr),
        .gfx_req         (gfx_req),
        .gfx_addr        (gfx_req_addr),
        .main_resp_valid (main_resp_valid),
        .gfx_resp_valid  (gfx_resp_valid),
        .resp_data       (arb_resp_data),
        .ba_addr         (ba_addr),
        .ba_rd           (ba_rd),
        .ba_ack          (ba_ack),
        .ba_rdy          (ba_rdy),
        .data_read       (data_read)
    );

    prog_loader u_loader (
        .VB          (VB),
        .arst_n      (arst_n),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_data  (ioctl_data),
        .ioctl_wr    (ioctl_wr),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prog_we     (prog_we),
        .dwnld_busy  (dwnld_busy)
    );

endmodule

`default_nettype wire

//--- verilog/prog_loader.sv
// ROM download path that packs ioctl bytes into 16-bit SDRAM programming writes
`timescale 1ns/1ps
`default_nettype none

`include "game_consts.svh"

module prog_loader (
    input  logic                   VB,
    input  logic                   arst_n,
    input  logic                   downloading,
    input  logic [24:0]            ioctl_addr,
    input  logic [7:0]             ioctl_data,
    input  logic                   ioctl_wr,
    output logic [`GAME_BA_AW-1:0] prog_addr,
    output logic [`GAME_DW-1:0]    prog_data,
    output logic                   prog_we,
    output logic                   dwnld_busy
);

    logic [7:0] even_byte;

    // Busy until the last packed word has been written
    assign dwnld_busy = downloading | prog_we;

    always_ff @(posedge VB or negedge arst_n) begin
        if (!arst_n) begin
            prog_we <= 1'b0;
        end else begin
            prog_we <= ioctl_wr & ioctl_addr[0];
        end
    end

    // Low byte first, the odd byte completes the word
    always_ff @(posedge VB) begin
        if (ioctl_wr) begin
            if (!ioctl_addr[0]) begin
                even_byte <= ioctl_data;
            end else begin
                prog_addr <= ioctl_addr[`GAME_BA_AW:1];
                prog_data <= {ioctl_data, even_byte};
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/bank_arbiter.sv
// Fixed-priority arbiter mapping the MAIN and GFX slots onto one read-only SDRAM bank
`timescale 1ns/1ps
`default_nettype none

`include "game_consts.svh"

module bank_arbiter (
    input  logic                    VB,
    input  logic                    arst_n,
    input  logic                    hold,
    input  logic                    main_req,
    input  logic [`GAME_ROM_AW-1:0] main_addr,
    input  logic                    gfx_req,
    input  logic [`GAME_ROM_AW-1:0] gfx_addr,
    output logic                    main_resp_valid,
    output logic                    gfx_resp_valid,
    output logic [`GAME_DW-1:0]     resp_data,
    output logic [`GAME_BA_AW-1:0]  ba_addr,
    output logic                    ba_rd,
    input  logic                    ba_ack,
    input  logic                    ba_rdy,
    input  logic [`GAME_DW-1:0]     data_read
);

    import game_pkg::*;

    arb_state_e               state;
    client_e                  owner;
    logic [`GAME_BA_AW-1:0]   main_ba_addr;
    logic [`GAME_BA_AW-1:0]   gfx_ba_addr;
    logic                     rdy_now;

    // Bank map, graphics sits above the program region
    assign main_ba_addr = `GAME_BA_AW'(main_addr);
    assign gfx_ba_addr  = `GAME_BA_AW'(gfx_addr) + `GAME_GFX_OFFSET;

    // Response goes back on the rdy cycle itself
    assign rdy_now         = (state == WAIT_RDY) && ba_rdy;
    assign main_resp_valid = rdy_now && (owner == MAIN);
    assign gfx_resp_valid  = rdy_now && (owner == GFX);
    assign resp_data       = data_read;

    always_ff @(posedge VB or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
            owner <= MAIN;
            ba_rd <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    // MAIN has priority, nothing starts during a download
                    if (!hold && (main_req || gfx_req)) begin
                        owner <= main_req ? MAIN : GFX;
                        ba_rd <= 1'b1;
                        state <= WAIT_ACK;
                    end
                end
                WAIT_ACK: begin
                    if (ba_ack) begin
                        ba_rd <= 1'b0;
                        state <= WAIT_RDY;
                    end
                end
                WAIT_RDY: begin
                    if (ba_rdy) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    ba_rd <= 1'b0;
                    state <= IDLE;
                end
            endcase
        end
    end

    // Address is latched with the request and held until ack
    always_ff @(posedge VB) begin
        if (state == IDLE && !hold && (main_req || gfx_req)) begin
            ba_addr <= main_req ? main_ba_addr : gfx_ba_addr;
        end
    end

endmodule

`default_nettype wire

//--- verilog/rom_slot.sv
// ROM client slot: one cached word per client, requests the bank arbiter on a miss
`timescale 1ns/1ps
`default_nettype none

`include "game_consts.svh"

module rom_slot (
    input  logic                    VB,
    input  logic                    arst_n,
    input  logic                    flush,
    input  logic                    cs,
    input  logic [`GAME_ROM_AW-1:0] addr,
    output logic [`GAME_DW-1:0]     data,
    output logic                    ok,
    output logic                    req,
    output logic [`GAME_ROM_AW-1:0] req_addr,
    input  logic                    resp_valid,
    input  logic [`GAME_DW-1:0]     resp_data
);

    import game_pkg::*;

    logic                    valid;
    logic [`GAME_ROM_AW-1:0] tag;
    rom_word_t               cache;
    logic                    hit;

    // Hit is combinational so ok tracks addr in the same cycle
    assign hit  = valid && (tag == addr);
    assign ok   = cs & hit;
    assign data = cache;

    always_ff @(posedge VB or negedge arst_n) begin
        if (!arst_n) begin
            valid <= 1'b0;
            req   <= 1'b0;
        end else begin
            if (resp_valid) begin
                req   <= 1'b0;
                valid <= 1'b1;
            end else if (cs && !hit && !req) begin
                req <= 1'b1;
            end
            // Download in progress overrides a fill
            if (flush) begin
                valid <= 1'b0;
            end
        end
    end

    // Tag and data follow the outstanding request
    always_ff @(posedge VB) begin
        if (cs && !hit && !req) begin
            req_addr <= addr;
        end
        if (resp_valid) begin
            tag   <= req_addr;
            cache <= resp_data;
        end
    end

endmodule

`default_nettype wire

//--- verilog/game_cen.sv
// Pixel and CPU clock enables derived from VB, with a turbo CPU speed select
`timescale 1ns/1ps
`default_nettype none

`include "game_consts.svh"

module game_cen (
    input  logic VB,
    input  logic arst_n,
    input  logic turbo,
    output logic pxl_cen,
    output logic cpu_cen
);

    localparam int unsigned CW = $clog2(`GAME_PXL_DIV);

    logic [CW-1:0] cnt;

    // Free running divider
    always_ff @(posedge VB or negedge arst_n) begin
        if (!arst_n) begin
            cnt     <= '0;
            pxl_cen <= 1'b0;
            cpu_cen <= 1'b0;
        end else begin
            if (cnt == CW'(`GAME_PXL_DIV - 1)) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
            pxl_cen <= (cnt == '0);
            // Turbo doubles the CPU rate, every even count
            cpu_cen <= (cnt == '0) | (turbo & ~cnt[0]);
        end
    end

endmodule

`default_nettype wire

//--- verilog/game_pkg.sv
// Types shared by the ROM slots, the bank arbiter and the top level
`default_nettype none

`include "game_consts.svh"

package game_pkg;

    // Bank arbiter FSM
    typedef enum logic [1:0] {
        IDLE,
        WAIT_ACK,
        WAIT_RDY
    } arb_state_e;

    // Which ROM client owns the bank
    typedef enum logic {
        MAIN,
        GFX
    } client_e;

    // One ROM data word as seen by the clients
    typedef logic [`GAME_DW-1:0] rom_word_t;

endpackage

`default_nettype wire

//--- verilog/game_consts.svh
// Shared widths and divide counts for the game memory slice, included by every RTL file
`ifndef GAME_CONSTS_SVH
`define GAME_CONSTS_SVH

// SDRAM bank word address width
`define GAME_BA_AW 22

// Client ROM word address width
`define GAME_ROM_AW 20

// Data word width on both the bank and the clients
`define GAME_DW 16

// Pixel enable period in clocks
`define GAME_PXL_DIV 4

// Graphics region starts 1M words into the bank,
// right after the main CPU program
`define GAME_GFX_OFFSET 22'h100000

`endif
